/* Makefile */
# Verilator build and run of the running median filter testbench

VERILATOR ?= verilator
TOP       ?= tb_median_filter
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/100ps -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
+incdir+.
median_pkg.sv
sort_cell.sv
median_sorter.sv
sample_history.sv
median_filter.sv
median_filter_asserts.sv
tb_median_filter.sv

/* median_defs.svh */
// running median filter constants
// sample width, window length and the pad value used at reset
`ifndef MEDIAN_DEFS_SVH
`define MEDIAN_DEFS_SVH

// sample width in bits
`define MF_DATA_W 8

// default window length, any odd value of at least 3
`define MF_WIN_LEN 9

// reset fill of the chain and history
// inserting and deleting this same value leaves the chain untouched
`define MF_PAD_VALUE {`MF_DATA_W{1'b1}}

`endif

/* median_filter.sv */
// running median filter top level
// history and sorter update on each accept, median registered one cycle later
`timescale 1ns/100ps
`include "median_defs.svh"

module median_filter (
  input  logic               clk,
  input  logic               RST,
  input  median_pkg::pixel_t din,
  input  logic               in_en,
  output median_pkg::pixel_t dout,
  output logic               out_valid
);

  median_pkg::pixel_t      old_sample;
  median_pkg::pixel_t      median;
  median_pkg::fill_state_t fill_state;
  logic                    accept_q;

  sample_history #(
    .WIN_LEN (`MF_WIN_LEN)
  ) u_history (
    .clk        (clk),
    .RST        (RST),
    .in_en      (in_en),
    .din        (din),
    .old_sample (old_sample),
    .fill_state (fill_state)
  );

  // departing sample is deleted in the same edge the new one goes in
  median_sorter #(
    .WIN_LEN (`MF_WIN_LEN)
  ) u_sorter (
    .clk    (clk),
    .RST    (RST),
    .in_en  (in_en),
    .ins    (din),
    .del    (old_sample),
    .median (median)
  );

  // an accept flag that lines up with the settled chain
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= in_en;
    end
  end

  // output register, one pulse per accept once the window is full
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      out_valid <= accept_q && (fill_state == median_pkg::FULL);
      if (accept_q && fill_state == median_pkg::FULL) begin
        dout <= median;
      end
    end
  end

endmodule

/* median_filter_asserts.sv */
// port-level checks on the running median filter
// bound into every median_filter instance
`timescale 1ns/100ps

module median_filter_asserts (
  input logic               clk,
  input logic               RST,
  input logic               in_en,
  input logic               out_valid,
  input median_pkg::pixel_t dout
);

  // sampled values lag one edge, so the accept shows up two samples back
  property p_valid_after_accept;
    @(posedge clk) disable iff (RST) out_valid |-> $past(in_en, 2);
  endproperty

  property p_quiet_in_reset;
    @(posedge clk) RST |-> !out_valid;
  endproperty

  property p_dout_known;
    @(posedge clk) disable iff (RST) out_valid |-> !$isunknown(dout);
  endproperty

  a_valid_after_accept: assert property (p_valid_after_accept)
    else $error("out_valid without an accept one cycle before");

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("out_valid high during reset");

  a_dout_known: assert property (p_dout_known)
    else $error("dout unknown while out_valid is high");

endmodule

bind median_filter median_filter_asserts u_asserts (
  .clk       (clk),
  .RST       (RST),
  .in_en     (in_en),
  .out_valid (out_valid),
  .dout      (dout)
);

/* median_pkg.sv */
// running median filter package
// sample type plus the enums shared by the sorter cells and the history
`include "median_defs.svh"

package median_pkg;

  // one unsigned sample
  typedef logic [`MF_DATA_W-1:0] pixel_t;

  // what a sort cell loads on the next edge
  typedef enum logic [1:0] {
    HOLD      = 2'd0,
    TAKE_PREV = 2'd1,
    TAKE_NEXT = 2'd2,
    TAKE_INS  = 2'd3
  } cell_move_t;

  // window fill tracking
  // FULL once a whole window of samples has been accepted
  typedef enum logic {
    FILLING = 1'b0,
    FULL    = 1'b1
  } fill_state_t;

endpackage

/* median_sorter.sv */
// sorted chain of compare cells for the running median
// one insert and one delete per accepted sample, middle cell is the median
`timescale 1ns/100ps
`include "median_defs.svh"

module median_sorter #(
  parameter int WIN_LEN = `MF_WIN_LEN
) (
  input  logic               clk,
  input  logic               RST,
  input  logic               in_en,
  input  median_pkg::pixel_t ins,
  input  median_pkg::pixel_t del,
  output median_pkg::pixel_t median
);

  localparam int MID = WIN_LEN / 2;

  // the middle tap only exists for an odd window
  if (WIN_LEN < 3 || (WIN_LEN % 2) == 0) begin : g_bad_len
    $error("median_sorter needs an odd WIN_LEN of at least 3");
  end

  median_pkg::pixel_t ins_eff;
  median_pkg::pixel_t del_eff;
  median_pkg::pixel_t cell_value [WIN_LEN];

  // idle cycles present pad for both, so every cell picks HOLD
  assign ins_eff = in_en ? ins : median_pkg::pixel_t'(`MF_PAD_VALUE);
  assign del_eff = in_en ? del : median_pkg::pixel_t'(`MF_PAD_VALUE);

  // chain in ascending order, index 0 is the smallest entry
  for (genvar i = 0; i < WIN_LEN; i++) begin : g_cell
    median_pkg::pixel_t prev_val;
    median_pkg::pixel_t next_val;

    // bottom cell sees zero below it
    if (i == 0) begin : g_bottom
      assign prev_val = '0;
    end else begin : g_prev
      assign prev_val = cell_value[i-1];
    end

    // top cell sees the pad value above it
    if (i == WIN_LEN - 1) begin : g_top
      assign next_val = `MF_PAD_VALUE;
    end else begin : g_next
      assign next_val = cell_value[i+1];
    end

    sort_cell u_cell (
      .clk   (clk),
      .RST   (RST),
      .ins   (ins_eff),
      .del   (del_eff),
      .prev  (prev_val),
      .next  (next_val),
      .value (cell_value[i])
    );
  end

  // median straight off the middle cell
  assign median = cell_value[MID];

endmodule

/* sample_history.sv */
// sample history for the running median
// delay line returning the sample that leaves the window, plus fill tracking
`timescale 1ns/100ps
`include "median_defs.svh"

module sample_history #(
  parameter int WIN_LEN = `MF_WIN_LEN
) (
  input  logic                    clk,
  input  logic                    RST,
  input  logic                    in_en,
  input  median_pkg::pixel_t      din,
  output median_pkg::pixel_t      old_sample,
  output median_pkg::fill_state_t fill_state
);

  localparam int CNT_W = $clog2(WIN_LEN + 1);

  median_pkg::pixel_t hist [WIN_LEN];
  logic [CNT_W-1:0]   fill_cnt;

  // newest at index 0, oldest at the far end
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < WIN_LEN; i++) begin
        hist[i] <= `MF_PAD_VALUE;
      end
    end else if (in_en) begin
      hist[0] <= din;
      for (int i = 1; i < WIN_LEN; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // the entry pushed out by this accept
  assign old_sample = hist[WIN_LEN-1];

  // count accepts until the window is full, then stop
  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      fill_cnt   <= '0;
      fill_state <= median_pkg::FILLING;
    end else if (in_en && fill_state == median_pkg::FILLING) begin
      fill_cnt <= fill_cnt + 1'b1;
      // this accept brings in sample number WIN_LEN
      if (fill_cnt == CNT_W'(WIN_LEN - 1)) begin
        fill_state <= median_pkg::FULL;
      end
    end
  end

endmodule

/* sort_cell.sv */
// one cell of the ascending median chain
// applies the insert/delete compare rule against its two neighbours
`timescale 1ns/100ps
`include "median_defs.svh"

module sort_cell (
  input  logic               clk,
  input  logic               RST,
  input  median_pkg::pixel_t ins,
  input  median_pkg::pixel_t del,
  input  median_pkg::pixel_t prev,
  input  median_pkg::pixel_t next,
  output median_pkg::pixel_t value
);

  median_pkg::cell_move_t move;
  median_pkg::pixel_t     value_nxt;

  // decide the move for this cycle
  always_comb begin
    move = median_pkg::HOLD;
    if (ins < del) begin
      // entries in (ins, del] slide up by one place
      if (value > ins && value <= del) begin
        if (prev > ins) begin
          move = median_pkg::TAKE_PREV;
        end else begin
          move = median_pkg::TAKE_INS;
        end
      end
    end else if (ins > del) begin
      // mirror case, entries in [del, ins) slide down
      if (value < ins && value >= del) begin
        if (next < ins) begin
          move = median_pkg::TAKE_NEXT;
        end else begin
          move = median_pkg::TAKE_INS;
        end
      end
    end
    // equal ins and del keeps the chain as it is
  end

  always_comb begin
    case (move)
      median_pkg::TAKE_PREV: value_nxt = prev;
      median_pkg::TAKE_NEXT: value_nxt = next;
      median_pkg::TAKE_INS:  value_nxt = ins;
      default:               value_nxt = value;
    endcase
  end

  always_ff @(posedge clk or posedge RST) begin
    if (RST) begin
      value <= `MF_PAD_VALUE;
    end else begin
      value <= value_nxt;
    end
  end

endmodule

/* tb_median_filter.sv */
// testbench for the running median filter
// random and directed streams checked against a sorting model of the window
`timescale 1ns/100ps
`include "median_defs.svh"

module tb_median_filter;

  localparam int CLK_PERIOD = 8;
  localparam int WIN        = `MF_WIN_LEN;
  localparam median_pkg::pixel_t PAD = `MF_PAD_VALUE;

  // cycle budget of each test summed for the watchdog
  localparam int T1_CYCLES    = 20;
  localparam int T2_CYCLES    = 20;
  localparam int T3_CYCLES    = 1000;
  localparam int T4_CYCLES    = 1100;
  localparam int T5_CYCLES    = 60;
  localparam int T6_CYCLES    = 300;
  localparam int TOTAL_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                              + T5_CYCLES + T6_CYCLES;
  localparam int MARGIN_NS    = 2000;

  logic               clk;
  logic               RST;
  median_pkg::pixel_t din;
  logic               in_en;
  median_pkg::pixel_t dout;
  logic               out_valid;

  integer seed;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     fail_cnt;
  int     pulse_cnt;
  int     accept_cnt;

  // model of the window and the two-stage output expectation
  median_pkg::pixel_t win_q [$];
  median_pkg::pixel_t model_dout;
  logic               pipe_a_valid;
  logic               pipe_b_valid;
  median_pkg::pixel_t pipe_a_dout;
  median_pkg::pixel_t pipe_b_dout;

  median_filter UUT (
    .clk       (clk),
    .RST       (RST),
    .din       (din),
    .in_en     (in_en),
    .dout      (dout),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("watchdog expired, the tests did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic median_pkg::pixel_t rand_sample();
    integer r;
    r = $random(seed);
    return r[`MF_DATA_W-1:0];
  endfunction

  // missing samples count as pad, then sort and take the middle
  function automatic median_pkg::pixel_t window_median();
    median_pkg::pixel_t vals [WIN];
    median_pkg::pixel_t tmp;
    int                 j;
    for (int i = 0; i < WIN; i++) begin
      vals[i] = PAD;
    end
    for (int i = 0; i < win_q.size(); i++) begin
      vals[i] = win_q[i];
    end
    for (int i = 1; i < WIN; i++) begin
      tmp = vals[i];
      j   = i - 1;
      while (j >= 0 && vals[j] > tmp) begin
        vals[j+1] = vals[j];
        j--;
      end
      vals[j+1] = tmp;
    end
    return vals[WIN/2];
  endfunction

  task automatic model_reset();
    win_q.delete();
    model_dout   = '0;
    accept_cnt   = 0;
    pipe_a_valid = 1'b0;
    pipe_b_valid = 1'b0;
    pipe_a_dout  = '0;
    pipe_b_dout  = '0;
  endtask

  task automatic model_accept(input median_pkg::pixel_t d);
    win_q.push_back(d);
    if (win_q.size() > WIN) begin
      win_q.delete(0);
    end
    accept_cnt++;
    if (accept_cnt >= WIN) begin
      model_dout   = window_median();
      pipe_a_valid = 1'b1;
    end
    pipe_a_dout = model_dout;
  endtask

  task automatic check_outputs();
    if (out_valid === 1'b1) begin
      pulse_cnt++;
    end
    check_cnt += 2;
    assert (out_valid === pipe_b_valid) else begin
      $display("ERR %0t: out_valid is %b, expected %b", $time, out_valid, pipe_b_valid);
      err_cnt++;
    end
    assert (dout === pipe_b_dout) else begin
      $display("ERR %0t: dout is %0d, expected %0d", $time, dout, pipe_b_dout);
      err_cnt++;
    end
  endtask

  // check what the last edge produced and drive the next input
  task automatic step(input logic en, input median_pkg::pixel_t d);
    @(negedge clk);
    check_outputs();
    pipe_b_valid = pipe_a_valid;
    pipe_b_dout  = pipe_a_dout;
    pipe_a_valid = 1'b0;
    pipe_a_dout  = model_dout;
    in_en        = en;
    din          = d;
    if (en) begin
      model_accept(d);
    end
  endtask

  task automatic drain();
    repeat (2) step(1'b0, rand_sample());
  endtask

  task automatic apply_reset();
    @(negedge clk);
    RST   = 1'b1;
    in_en = 1'b0;
    model_reset();
    repeat (4) begin
      @(negedge clk);
      check_cnt++;
      assert (out_valid === 1'b0 && dout === '0) else begin
        $display("ERR %0t: outputs not cleared in reset, out_valid %b dout %0d",
                 $time, out_valid, dout);
        err_cnt++;
      end
    end
    RST = 1'b0;
  endtask

  task automatic check_pulses(input int expected);
    check_cnt++;
    assert (pulse_cnt == expected) else begin
      $display("ERR %0t: %0d out_valid pulses, expected %0d", $time, pulse_cnt, expected);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: passed", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  initial begin
    int     errs_before;
    int     accepted;
    int     gap;
    integer r;
    seed      = 32'hc361_d086;
    RST       = 1'b1;
    in_en     = 1'b0;
    din       = '0;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    pulse_cnt = 0;
    model_reset();

    // outputs stay cleared while idle
    errs_before = err_cnt;
    apply_reset();
    pulse_cnt = 0;
    repeat (8) step(1'b0, rand_sample());
    check_pulses(0);
    finish_test("reset state", errs_before);

    // no pulse until a whole window is in
    errs_before = err_cnt;
    pulse_cnt   = 0;
    repeat (WIN - 1) step(1'b1, rand_sample());
    drain();
    check_pulses(0);
    step(1'b1, rand_sample());
    drain();
    check_pulses(1);
    finish_test("window fill delay", errs_before);

    // random stream accepted on about three cycles in four
    errs_before = err_cnt;
    accepted    = 0;
    while (accepted < 400) begin
      r = $random(seed);
      if ((r & 3) != 0) begin
        step(1'b1, rand_sample());
        accepted++;
      end else begin
        step(1'b0, rand_sample());
      end
    end
    drain();
    finish_test("random stream", errs_before);

    // idle gaps of up to 15 cycles between accepts
    errs_before = err_cnt;
    apply_reset();
    pulse_cnt = 0;
    for (int n = 0; n < 60; n++) begin
      r   = $random(seed);
      gap = r & 15;
      repeat (gap) step(1'b0, rand_sample());
      step(1'b1, rand_sample());
    end
    drain();
    check_pulses(60 - (WIN - 1));
    finish_test("idle gaps", errs_before);

    // real pad-valued samples go through the chain like any other
    errs_before = err_cnt;
    repeat (WIN + 3) step(1'b1, '0);
    repeat (WIN + 3) step(1'b1, PAD);
    for (int n = 0; n < 2 * WIN; n++) begin
      step(1'b1, (n % 2 == 0) ? '0 : PAD);
    end
    drain();
    finish_test("extreme runs", errs_before);

    // reset in the middle of a stream starts a fresh window
    errs_before = err_cnt;
    repeat (20) step(1'b1, rand_sample());
    apply_reset();
    pulse_cnt = 0;
    repeat (WIN - 1) step(1'b1, rand_sample());
    drain();
    check_pulses(0);
    step(1'b1, rand_sample());
    drain();
    check_pulses(1);
    for (int n = 0; n < 100; n++) begin
      r = $random(seed);
      step((r & 1) != 0, rand_sample());
    end
    drain();
    finish_test("mid-stream reset", errs_before);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
